// ==== all.f ====
+incdir+design
design/mm_bus_pkg.sv
design/mm_periph_pkg.sv
design/mm_addr_decode.sv
design/mm_dp_ram.sv
design/mm_data_resp.sv
design/mm_irq_timer.sv
design/mm_debug_req_gen.sv
design/mm_ram.sv
sim/tb_mm_ram.sv

// ==== design/mm_addr_decode.sv ====
/*
 * Address decoder of the memory model.
 * Sends each data request to RAM or to a peripheral, moves the debug code
 * window to the top of RAM on both ports and raises the test status pulses.
 */
`timescale 1ns/1ps
`include "mm_ram_defines.svh"

module mm_addr_decode (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mm_bus_pkg::data_req_t      data_req_i,
    input  mm_bus_pkg::bus_addr_t      instr_addr_i,
    input  mm_bus_pkg::bus_addr_t      dm_halt_addr_i,
    output mm_bus_pkg::ram_req_t       ram_req_o,
    output mm_bus_pkg::ram_addr_t      instr_ram_addr_o,
    output mm_periph_pkg::periph_wr_t  periph_wr_o,
    output mm_bus_pkg::rdata_sel_e     rdata_sel_o,
    output logic                       ram_access_o,
    output logic                       tests_passed_o,
    output logic                       tests_failed_o,
    output logic                       exit_valid_o,
    output mm_bus_pkg::bus_data_t      exit_value_o
);
    import mm_bus_pkg::*;

    localparam bus_addr_t RAM_SIZE = bus_addr_t'(2 ** `MM_RAM_ADDR_WIDTH);
    localparam bus_addr_t DBG_SIZE = bus_addr_t'(2 ** `MM_DBG_ADDR_WIDTH);
    localparam ram_addr_t DBG_BASE = ram_addr_t'(RAM_SIZE - DBG_SIZE);

    logic ram_map;
    logic wr;
    logic hit_status;
    logic hit_exit;
    logic hit_tmask;
    logic hit_tcnt;
    logic hit_dbg_ctrl;

    function automatic logic in_dbg_window(bus_addr_t addr, bus_addr_t halt);
        return (addr >= halt) && (addr < halt + DBG_SIZE);
    endfunction

    // debug window goes to the top of RAM, anything else keeps its low bits
    function automatic ram_addr_t remap(bus_addr_t addr, bus_addr_t halt);
        ram_addr_t offset;
        offset = ram_addr_t'(addr - halt);
        if (in_dbg_window(addr, halt)) begin
            return offset + DBG_BASE;
        end
        return ram_addr_t'(addr);
    endfunction

    assign ram_map = (data_req_i.addr < RAM_SIZE) ||
                     in_dbg_window(data_req_i.addr, dm_halt_addr_i);
    assign wr      = data_req_i.req && data_req_i.we;

    // peripheral registers only answer outside the RAM map
    assign hit_status   = !ram_map && (data_req_i.addr == `MM_ADDR_TEST_STATUS);
    assign hit_exit     = !ram_map && (data_req_i.addr == `MM_ADDR_EXIT);
    assign hit_tmask    = !ram_map && (data_req_i.addr == `MM_ADDR_TIMER_MASK);
    assign hit_tcnt     = !ram_map && (data_req_i.addr == `MM_ADDR_TIMER_CNT);
    assign hit_dbg_ctrl = !ram_map && (data_req_i.addr == `MM_ADDR_DEBUG_CTRL);

    assign ram_access_o = data_req_i.req && ram_map;

    assign ram_req_o = '{
        en:    ram_access_o,
        we:    data_req_i.we,
        be:    data_req_i.be,
        addr:  remap(data_req_i.addr, dm_halt_addr_i),
        wdata: data_req_i.wdata
    };

    assign instr_ram_addr_o = remap(instr_addr_i, dm_halt_addr_i);

    assign periph_wr_o = '{
        timer_mask_we: wr && hit_tmask,
        timer_cnt_we:  wr && hit_tcnt,
        debug_we:      wr && hit_dbg_ctrl,
        wdata:         data_req_i.wdata
    };

    // only RAM reads carry data back, reads elsewhere are errors
    always_comb begin
        if (data_req_i.req && !data_req_i.we) begin
            rdata_sel_o = ram_map ? SEL_RAM : SEL_ERR;
        end else begin
            rdata_sel_o = SEL_ZERO;
        end
    end

    // ---------------------------------------------------------------------
    // test status
    // ---------------------------------------------------------------------
    assign tests_passed_o = wr && hit_status && (data_req_i.wdata == `MM_TEST_PASS_VALUE);
    assign tests_failed_o = wr && hit_status && (data_req_i.wdata == `MM_TEST_FAIL_VALUE);
    assign exit_valid_o   = wr && hit_exit;
    assign exit_value_o   = (wr && hit_exit) ? data_req_i.wdata : '0;

    a_write_mapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr |-> (ram_map || hit_status || hit_exit || hit_tmask || hit_tcnt || hit_dbg_ctrl))
        else $error("out of bounds write to %08x with %08x",
                    data_req_i.addr, data_req_i.wdata);

endmodule

// ==== design/mm_bus_pkg.sv ====
/*
 * Bus types of the memory model.
 * Address and data words, the core data request, the decoded RAM request
 * and the select that tells the response path who answers.
 */
`include "mm_ram_defines.svh"

package mm_bus_pkg;

    typedef logic [31:0]                      bus_addr_t;
    typedef logic [31:0]                      bus_data_t;
    typedef logic [3:0]                       bus_be_t;
    typedef logic [`MM_RAM_ADDR_WIDTH-1:0]    ram_addr_t;
    typedef logic [`MM_INSTR_RDATA_WIDTH-1:0] instr_data_t;

    // data request as issued by the core
    typedef struct packed {
        logic      req;
        logic      we;
        bus_be_t   be;
        bus_addr_t addr;
        bus_data_t wdata;
    } data_req_t;

    // data port B request after decode and remap
    typedef struct packed {
        logic      en;
        logic      we;
        bus_be_t   be;
        ram_addr_t addr;
        bus_data_t wdata;
    } ram_req_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_ZERO,
        SEL_ERR
    } rdata_sel_e;

endpackage

// ==== design/mm_data_resp.sv ====
/*
 * Data port response.
 * Grants every request in its own cycle and raises rvalid exactly one
 * cycle later, picking RAM data or zero for the answer.
 */
`timescale 1ns/1ps

module mm_data_resp (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    req_i,
    input  logic                    ram_access_i,
    input  mm_bus_pkg::rdata_sel_e  rdata_sel_i,
    input  mm_bus_pkg::bus_data_t   ram_rdata_i,
    output logic                    gnt_o,
    output logic                    rvalid_o,
    output mm_bus_pkg::bus_data_t   rdata_o
);
    import mm_bus_pkg::*;
    import mm_periph_pkg::*;

    resp_state_e state_q;
    resp_state_e state_d;
    rdata_sel_e  sel_q;

    // RAM always grants in the request cycle
    assign gnt_o = req_i;

    always_comb begin
        if (!req_i) begin
            state_d = IDLE;
        end else if (ram_access_i) begin
            state_d = RAM_VALID;
        end else begin
            state_d = PERIPH_VALID;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            sel_q   <= SEL_ZERO;
        end else begin
            state_q <= state_d;
            sel_q   <= rdata_sel_i;
        end
    end

    // state names the source answering in this cycle
    assign rvalid_o = (state_q != IDLE);

    always_comb begin
        unique case (state_q)
            RAM_VALID: rdata_o = (sel_q == SEL_RAM) ? ram_rdata_i : '0;
            default:   rdata_o = '0;
        endcase
    end

    a_no_err_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_o |-> (sel_q != SEL_ERR))
        else $error("out of bounds read answered with zero");

endmodule

// ==== design/mm_debug_req_gen.sv ====
/*
 * Debug request generator.
 * A control write sets a start delay, a level and an optional pulse
 * width. debug_req_o takes the level after the delay and, in pulse mode,
 * flips back once the width has run out.
 */
`timescale 1ns/1ps

module mm_debug_req_gen (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mm_periph_pkg::periph_wr_t  periph_wr_i,
    output logic                       debug_req_o
);
    import mm_periph_pkg::*;

    dbg_delay_t    delay_q;
    dbg_duration_t dur_q;
    logic          value_q;
    logic          ctrl_idle;
    dbg_delay_t    wr_delay;
    dbg_duration_t wr_dur;

    // ---------------------------------------------------------------------
    // control word
    //   31 level, 30 pulse mode, 28:16 pulse width, 14:0 start delay
    // ---------------------------------------------------------------------
    assign ctrl_idle = (delay_q == '0) && (dur_q == '0);

    // zero in a count field means one cycle
    assign wr_delay = (periph_wr_i.wdata[14:0] == '0) ? dbg_delay_t'(1)
                                                      : periph_wr_i.wdata[14:0];

    always_comb begin
        if (!periph_wr_i.wdata[30]) begin
            wr_dur = '0;
        end else if (periph_wr_i.wdata[28:16] == '0) begin
            wr_dur = dbg_duration_t'(1);
        end else begin
            wr_dur = periph_wr_i.wdata[28:16];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            delay_q     <= '0;
            dur_q       <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (periph_wr_i.debug_we && ctrl_idle) begin
            delay_q <= wr_delay;
            dur_q   <= wr_dur;
            value_q <= periph_wr_i.wdata[31];
        end else if (delay_q != '0) begin
            delay_q <= delay_q - 1'b1;
            if (delay_q == dbg_delay_t'(1)) begin
                debug_req_o <= value_q;
            end
        end else if (dur_q != '0) begin
            // pulse width only runs once the delay is over
            dur_q <= dur_q - 1'b1;
            if (dur_q == dbg_duration_t'(1)) begin
                debug_req_o <= !value_q;
            end
        end
    end

endmodule

// ==== design/mm_dp_ram.sv ====
/*
 * Dual-port byte RAM.
 * Port A reads a wide instruction line, port B reads and writes 32-bit
 * words with byte enables. Read data of both ports arrives one cycle later.
 */
`timescale 1ns/1ps
`include "mm_ram_defines.svh"

module mm_dp_ram (
    input  logic                     clk_i,
    input  logic                     instr_en_i,
    input  mm_bus_pkg::ram_addr_t    instr_addr_i,
    input  mm_bus_pkg::ram_req_t     data_req_i,
    output mm_bus_pkg::instr_data_t  instr_rdata_o,
    output mm_bus_pkg::bus_data_t    data_rdata_o
);
    import mm_bus_pkg::*;

    localparam int LINE_BYTES = `MM_INSTR_RDATA_WIDTH / 8;
    localparam int WORD_BYTES = $bits(bus_be_t);

    logic [7:0] mem [2 ** `MM_RAM_ADDR_WIDTH];

    // port A, line wraps at the end of RAM
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_addr_i + ram_addr_t'(i)];
            end
        end
    end

    // port B
    always_ff @(posedge clk_i) begin
        if (data_req_i.en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (data_req_i.we && data_req_i.be[i]) begin
                    mem[data_req_i.addr + ram_addr_t'(i)] <= data_req_i.wdata[8*i +: 8];
                end
                if (!data_req_i.we) begin
                    data_rdata_o[8*i +: 8] <= mem[data_req_i.addr + ram_addr_t'(i)];
                end
            end
        end
    end

    a_data_aligned: assert property (@(posedge clk_i)
        data_req_i.en |-> (data_req_i.addr[1:0] == 2'b00))
        else $error("unaligned data access at %04x", data_req_i.addr);

endmodule

// ==== design/mm_irq_timer.sv ====
/*
 * Interrupt timer.
 * Counts down from the written value and then loads the mask register
 * into the interrupt vector. Acknowledged IDs clear their own bit.
 */
`timescale 1ns/1ps

module mm_irq_timer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mm_periph_pkg::periph_wr_t  periph_wr_i,
    input  logic                       irq_ack_i,
    input  mm_periph_pkg::irq_id_t     irq_id_i,
    output mm_periph_pkg::irq_vec_t    irq_o
);
    import mm_periph_pkg::*;

    irq_vec_t   mask_q;
    timer_cnt_t cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= '0;
        end else begin
            if (periph_wr_i.timer_mask_we) begin
                mask_q <= irq_vec_t'(periph_wr_i.wdata);
            end

            // a count of zero stops the timer
            if (periph_wr_i.timer_cnt_we) begin
                cnt_q <= periph_wr_i.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            if (cnt_q == timer_cnt_t'(1)) begin
                irq_o <= mask_q;
            end else if (irq_ack_i) begin
                irq_o[irq_id_i] <= 1'b0;
            end
        end
    end

    a_one_timer_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(periph_wr_i.timer_mask_we && periph_wr_i.timer_cnt_we))
        else $error("timer mask and count written in the same cycle");

endmodule

// ==== design/mm_periph_pkg.sv ====
/*
 * Peripheral types of the memory model.
 * Write strobes to the timer and debugger, interrupt and counter types,
 * and the states of the data response FSM.
 */
`include "mm_ram_defines.svh"

package mm_periph_pkg;

    typedef logic [`MM_IRQ_WIDTH-1:0] irq_vec_t;
    typedef logic [4:0]               irq_id_t;
    typedef logic [31:0]              timer_cnt_t;

    // one strobe per writable peripheral register
    typedef struct packed {
        logic        timer_mask_we;
        logic        timer_cnt_we;
        logic        debug_we;
        logic [31:0] wdata;
    } periph_wr_t;

    typedef logic [14:0] dbg_delay_t;
    typedef logic [12:0] dbg_duration_t;

    typedef enum logic [1:0] {
        IDLE,
        PERIPH_VALID,
        RAM_VALID
    } resp_state_e;

endpackage

// ==== design/mm_ram.sv ====
/*
 * Memory model top level.
 * Dual-port RAM with instruction and data ports, plus test status,
 * interrupt timer and debug request peripherals on the data port.
 */
`timescale 1ns/1ps

module mm_ram (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mm_bus_pkg::bus_addr_t      dm_halt_addr_i,

    input  logic                       instr_req_i,
    input  mm_bus_pkg::bus_addr_t      instr_addr_i,
    output mm_bus_pkg::instr_data_t    instr_rdata_o,
    output logic                       instr_rvalid_o,
    output logic                       instr_gnt_o,

    input  mm_bus_pkg::data_req_t      data_req_i,
    output mm_bus_pkg::bus_data_t      data_rdata_o,
    output logic                       data_rvalid_o,
    output logic                       data_gnt_o,

    input  mm_periph_pkg::irq_id_t     irq_id_i,
    input  logic                       irq_ack_i,
    output mm_periph_pkg::irq_vec_t    irq_o,

    output logic                       debug_req_o,

    output logic                       tests_passed_o,
    output logic                       tests_failed_o,
    output logic                       exit_valid_o,
    output mm_bus_pkg::bus_data_t      exit_value_o
);
    import mm_bus_pkg::*;
    import mm_periph_pkg::*;

    ram_req_t   ram_req;
    ram_addr_t  instr_ram_addr;
    bus_data_t  ram_rdata;
    periph_wr_t periph_wr;
    rdata_sel_e rdata_sel;
    logic       ram_access;
    logic       instr_rvalid_q;

    // instruction port never stalls
    assign instr_gnt_o    = instr_req_i;
    assign instr_rvalid_o = instr_rvalid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    mm_addr_decode i_addr_decode (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .data_req_i       (data_req_i),
        .instr_addr_i     (instr_addr_i),
        .dm_halt_addr_i   (dm_halt_addr_i),
        .ram_req_o        (ram_req),
        .instr_ram_addr_o (instr_ram_addr),
        .periph_wr_o      (periph_wr),
        .rdata_sel_o      (rdata_sel),
        .ram_access_o     (ram_access),
        .tests_passed_o   (tests_passed_o),
        .tests_failed_o   (tests_failed_o),
        .exit_valid_o     (exit_valid_o),
        .exit_value_o     (exit_value_o)
    );

    mm_dp_ram i_dp_ram (
        .clk_i         (clk_i),
        .instr_en_i    (instr_req_i),
        .instr_addr_i  (instr_ram_addr),
        .data_req_i    (ram_req),
        .instr_rdata_o (instr_rdata_o),
        .data_rdata_o  (ram_rdata)
    );

    mm_data_resp i_data_resp (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (data_req_i.req),
        .ram_access_i (ram_access),
        .rdata_sel_i  (rdata_sel),
        .ram_rdata_i  (ram_rdata),
        .gnt_o        (data_gnt_o),
        .rvalid_o     (data_rvalid_o),
        .rdata_o      (data_rdata_o)
    );

    mm_irq_timer i_irq_timer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .periph_wr_i (periph_wr),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_o       (irq_o)
    );

    mm_debug_req_gen i_debug_req_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .periph_wr_i (periph_wr),
        .debug_req_o (debug_req_o)
    );

endmodule

// ==== design/mm_ram_defines.svh ====
/*
 * Memory model parameters.
 * Widths, memory map and magic values shared by the RAM model blocks.
 */
`ifndef MM_RAM_DEFINES_SVH
`define MM_RAM_DEFINES_SVH

// ---------------------------------------------------------------------------
// sizes
// ---------------------------------------------------------------------------
`define MM_RAM_ADDR_WIDTH     16
// debug code window, placed at the top of RAM
`define MM_DBG_ADDR_WIDTH     14
`define MM_INSTR_RDATA_WIDTH  128
`define MM_IRQ_WIDTH          32

// ---------------------------------------------------------------------------
// memory map
// ---------------------------------------------------------------------------
`define MM_ADDR_TEST_STATUS   32'h2000_0000
`define MM_ADDR_EXIT          32'h2000_0004
`define MM_ADDR_TIMER_MASK    32'h1500_0000
`define MM_ADDR_TIMER_CNT     32'h1500_0004
`define MM_ADDR_DEBUG_CTRL    32'h1500_0008

// test status magic values
`define MM_TEST_PASS_VALUE    32'd123456789
`define MM_TEST_FAIL_VALUE    32'd1

`endif

// ==== sim/tb_mm_ram.sv ====
/*
 * Testbench of the memory model.
 * Applies a table of bus operations to the RAM, the debug window, the test
 * status outputs, the interrupt timer and the debug request generator, and
 * checks each response against a byte-array model and the timing rules.
 */
`timescale 1ns/1ps
`include "mm_ram_defines.svh"

module tb_mm_ram;
    import mm_bus_pkg::*;
    import mm_periph_pkg::*;

    typedef enum logic [3:0] {
        OP_RAM_WR, OP_RAM_RD, OP_INSTR_RD, OP_PERIPH_WR, OP_ZERO_RD,
        OP_TIMER, OP_ACK, OP_DEBUG, OP_DEBUG_BUSY, OP_B2B
    } op_e;

    // one table row with the cycle budget it may take
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp;
        logic [15:0] cycles;
    } row_t;

    localparam bus_addr_t   HALT_ADDR = 32'h1a11_0000;
    localparam logic [31:0] BE_MIX    = 32'ha5c3_ffff;
    localparam int          MARGIN    = 50;

    logic        clk_i;
    logic        rst_ni;
    logic        instr_req;
    bus_addr_t   instr_addr;
    instr_data_t instr_rdata;
    logic        instr_rvalid;
    logic        instr_gnt;
    data_req_t   data_req;
    bus_data_t   data_rdata;
    logic        data_rvalid;
    logic        data_gnt;
    irq_id_t     irq_id;
    logic        irq_ack;
    irq_vec_t    irq;
    logic        debug_req;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    bus_data_t   exit_value;

    row_t        table_q[$];
    logic [7:0]  model [2 ** `MM_RAM_ADDR_WIDTH];
    integer      seed = 32'hdd8a4e0a;
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          cycle_limit = 100000;
    logic        dbg_level;
    irq_vec_t    irq_exp;

    mm_ram i_mm_ram (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dm_halt_addr_i (HALT_ADDR),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_rdata_o  (instr_rdata),
        .instr_rvalid_o (instr_rvalid),
        .instr_gnt_o    (instr_gnt),
        .data_req_i     (data_req),
        .data_rdata_o   (data_rdata),
        .data_rvalid_o  (data_rvalid),
        .data_gnt_o     (data_gnt),
        .irq_id_i       (irq_id),
        .irq_ack_i      (irq_ack),
        .irq_o          (irq),
        .debug_req_o    (debug_req),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the table did not finish", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic ram_addr_t map_addr(bus_addr_t addr);
        bus_addr_t win;
        win = bus_addr_t'(2 ** `MM_DBG_ADDR_WIDTH);
        if (addr >= HALT_ADDR && addr < HALT_ADDR + win) begin
            return ram_addr_t'(addr - HALT_ADDR + bus_addr_t'(2 ** `MM_RAM_ADDR_WIDTH) - win);
        end
        return ram_addr_t'(addr);
    endfunction

    function automatic bus_data_t model_word(bus_addr_t addr);
        ram_addr_t a;
        bus_data_t w;
        a = map_addr(addr);
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model[a + ram_addr_t'(i)];
        end
        return w;
    endfunction

    function automatic instr_data_t model_line(bus_addr_t addr);
        ram_addr_t   a;
        instr_data_t l;
        a = map_addr(addr);
        for (int i = 0; i < 16; i++) begin
            l[8*i +: 8] = model[a + ram_addr_t'(i)];
        end
        return l;
    endfunction

    task automatic model_write(input bus_addr_t addr, input bus_data_t wdata, input bus_be_t be);
        ram_addr_t a;
        a = map_addr(addr);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                model[a + ram_addr_t'(i)] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] want);
        checks++;
        assert (got === want) else begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // bus drivers
    // ------------------------------------------------------------------------
    task automatic drive_req(input logic req, input logic we, input bus_be_t be,
                             input bus_addr_t addr, input bus_data_t wdata);
        data_req.req   = req;
        data_req.we    = we;
        data_req.be    = be;
        data_req.addr  = addr;
        data_req.wdata = wdata;
    endtask

    // one request that returns just after the falling edge following its grant
    task automatic bus_access(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                              input bus_be_t be, input logic [2:0] flags,
                              output bus_data_t rdata);
        @(negedge clk_i);
        drive_req(1'b1, we, be, addr, wdata);
        #10;
        check("data_gnt_o", data_gnt, 1'b1);
        check("tests_passed_o", tests_passed, flags[0]);
        check("tests_failed_o", tests_failed, flags[1]);
        check("exit_valid_o", exit_valid, flags[2]);
        check("exit_value_o", exit_value, flags[2] ? wdata : 32'h0);
        @(negedge clk_i);
        drive_req(1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
        check("data_rvalid_o", data_rvalid, 1'b1);
        rdata = data_rdata;
        #10;
        check("data_gnt_o", data_gnt, 1'b0);
    endtask

    // first is the number of clock edges since the control write when called
    task automatic watch_debug(input bus_data_t ctrl, input int first);
        int   d;
        int   w;
        logic v;
        logic want;
        d = (ctrl[14:0] == 0) ? 1 : int'(ctrl[14:0]);
        if (!ctrl[30]) begin
            w = 0;
        end else begin
            w = (ctrl[28:16] == 0) ? 1 : int'(ctrl[28:16]);
        end
        v = ctrl[31];
        for (int j = first; j <= d + w; j++) begin
            if (j > first) begin
                @(negedge clk_i);
            end
            if (j < d) begin
                want = dbg_level;
            end else if (j < d + w || w == 0) begin
                want = v;
            end else begin
                want = !v;
            end
            check("debug_req_o", debug_req, want);
        end
        dbg_level = (w == 0) ? v : !v;
    endtask

    task automatic apply_row(input row_t r);
        bus_data_t rdata;
        case (r.op)
            OP_RAM_WR: begin
                bus_access(1'b1, r.addr, r.wdata, r.be, 3'b000, rdata);
                check("data_rdata_o", rdata, 32'h0);
                model_write(r.addr, r.wdata, r.be);
            end
            OP_RAM_RD: begin
                bus_access(1'b0, r.addr, 32'h0, r.be, 3'b000, rdata);
                check("data_rdata_o", rdata, model_word(r.addr));
            end
            OP_ZERO_RD: begin
                bus_access(1'b0, r.addr, 32'h0, r.be, 3'b000, rdata);
                check("data_rdata_o", rdata, 32'h0);
            end
            OP_PERIPH_WR: begin
                bus_access(1'b1, r.addr, r.wdata, r.be, r.exp[2:0], rdata);
                check("data_rdata_o", rdata, 32'h0);
            end
            OP_INSTR_RD: begin
                @(negedge clk_i);
                instr_req  = 1'b1;
                instr_addr = r.addr;
                #10;
                check("instr_gnt_o", instr_gnt, 1'b1);
                @(negedge clk_i);
                instr_req = 1'b0;
                check("instr_rvalid_o", instr_rvalid, 1'b1);
                check("instr_rdata_o", instr_rdata, model_line(r.addr));
            end
            OP_TIMER: begin
                bus_access(1'b1, r.addr, r.wdata, r.be, 3'b000, rdata);
                for (int j = 0; j <= int'(r.wdata); j++) begin
                    if (j > 0) begin
                        @(negedge clk_i);
                    end
                    check("irq_o", irq, (j == int'(r.wdata)) ? r.exp : irq_exp);
                end
                irq_exp = r.exp;
            end
            OP_ACK: begin
                @(negedge clk_i);
                irq_ack = 1'b1;
                irq_id  = r.addr[4:0];
                @(negedge clk_i);
                irq_ack = 1'b0;
                check("irq_o", irq, r.exp);
                irq_exp = r.exp;
            end
            OP_DEBUG: begin
                bus_access(1'b1, r.addr, r.wdata, r.be, 3'b000, rdata);
                watch_debug(r.wdata, 0);
            end
            OP_DEBUG_BUSY: begin
                // second control word arrives while the delay still runs
                bus_access(1'b1, r.addr, r.wdata, r.be, 3'b000, rdata);
                bus_access(1'b1, r.addr, r.exp, r.be, 3'b000, rdata);
                watch_debug(r.wdata, 2);
            end
            OP_B2B: begin
                @(negedge clk_i);
                drive_req(1'b1, 1'b0, 4'hf, r.addr, 32'h0);
                #10;
                check("data_gnt_o", data_gnt, 1'b1);
                @(negedge clk_i);
                check("data_rvalid_o", data_rvalid, 1'b1);
                check("data_rdata_o", data_rdata, model_word(r.addr));
                drive_req(1'b1, 1'b1, 4'hf, `MM_ADDR_TEST_STATUS, r.wdata);
                #10;
                check("data_gnt_o", data_gnt, 1'b1);
                @(negedge clk_i);
                drive_req(1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
                check("data_rvalid_o", data_rvalid, 1'b1);
                check("data_rdata_o", data_rdata, 32'h0);
                @(negedge clk_i);
                check("data_rvalid_o", data_rvalid, 1'b0);
            end
            default: begin
                $display("row with an unknown operation");
                errors++;
            end
        endcase
    endtask

    task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input logic [31:0] exp, input int cycles);
        row_t r;
        r.op     = op;
        r.addr   = addr;
        r.wdata  = wdata;
        r.be     = be;
        r.exp    = exp;
        r.cycles = 16'(cycles);
        table_q.push_back(r);
    endtask

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic build_table();
        // full words first and then partial writes that merge into them
        for (int i = 0; i < 8; i++) begin
            add_row(OP_RAM_WR, 32'h100 + 4 * (i % 4), $random(seed), BE_MIX[4*i +: 4], 0, 2);
        end
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RAM_RD, 32'h100 + 4 * i, 0, 4'hf, 0, 2);
        end
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RAM_WR, HALT_ADDR + 32'h80 + 4 * i, $random(seed), 4'hf, 0, 2);
        end
        add_row(OP_RAM_RD, 32'h0000_c084, 0, 4'hf, 0, 2);
        add_row(OP_RAM_RD, HALT_ADDR + 32'h88, 0, 4'hf, 0, 2);
        add_row(OP_INSTR_RD, HALT_ADDR + 32'h80, 0, 4'hf, 0, 2);
        add_row(OP_INSTR_RD, 32'h100, 0, 4'hf, 0, 2);
        // exp holds {exit_valid, failed, passed}
        add_row(OP_PERIPH_WR, `MM_ADDR_TEST_STATUS, `MM_TEST_PASS_VALUE, 4'hf, 32'h1, 2);
        add_row(OP_PERIPH_WR, `MM_ADDR_TEST_STATUS, `MM_TEST_FAIL_VALUE, 4'hf, 32'h2, 2);
        add_row(OP_PERIPH_WR, `MM_ADDR_TEST_STATUS, 32'd5, 4'hf, 32'h0, 2);
        add_row(OP_PERIPH_WR, `MM_ADDR_EXIT, 32'h0000_0abc, 4'hf, 32'h4, 2);
        add_row(OP_PERIPH_WR, `MM_ADDR_TIMER_MASK, 32'h0000_0a05, 4'hf, 32'h0, 2);
        add_row(OP_TIMER, `MM_ADDR_TIMER_CNT, 32'd5, 4'hf, 32'h0000_0a05, 7);
        add_row(OP_ACK, 32'd2, 0, 4'h0, 32'h0000_0a01, 2);
        add_row(OP_ACK, 32'd11, 0, 4'h0, 32'h0000_0201, 2);
        // a pulse high after 3 for 4 and then a level high after 6
        add_row(OP_DEBUG, `MM_ADDR_DEBUG_CTRL, 32'hc004_0003, 4'hf, 0, 10);
        add_row(OP_DEBUG, `MM_ADDR_DEBUG_CTRL, 32'h8000_0006, 4'hf, 0, 9);
        add_row(OP_DEBUG_BUSY, `MM_ADDR_DEBUG_CTRL, 32'h0000_0008, 4'hf, 32'h8000_0001, 12);
        add_row(OP_B2B, 32'h104, 32'h0, 4'hf, 0, 4);
        add_row(OP_ZERO_RD, `MM_ADDR_TIMER_MASK, 0, 4'hf, 0, 2);
    endtask

    initial begin
        int  total;
        int  row_err;
        op_e op;
        rst_ni     = 1'b0;
        instr_req  = 1'b0;
        instr_addr = 32'h0;
        irq_id     = '0;
        irq_ack    = 1'b0;
        dbg_level  = 1'b0;
        irq_exp    = '0;
        drive_req(1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
        build_table();
        total = 0;
        foreach (table_q[i]) begin
            total += int'(table_q[i].cycles);
        end
        cycle_limit = total + 10 + MARGIN;

        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (table_q[i]) begin
            row_err = errors;
            op      = table_q[i].op;
            apply_row(table_q[i]);
            $display("row %0d %s: %s", i, op.name(), (errors == row_err) ? "ok" : "FAILED");
        end

        $display("rows %0d, checks %0d, errors %0d", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
